//--- hw/chan_est_pkg.sv
package chan_est_pkg;

    // Channel model size.
    localparam int EST_DEPTH = 30;
    localparam int ERR_LANES = 32;

    // Output tap and internal accumulator widths.
    localparam int EST_W   = 11;
    localparam int ADAPT_W = 18;
    localparam int ACC_W   = EST_W + ADAPT_W;

    // Error lane width and gain shift width.
    localparam int ERR_W  = 9;
    localparam int GAIN_W = $clog2(ADAPT_W);

    // Tap position.
    localparam int TAP_IDX_W = 5;
    localparam logic [TAP_IDX_W-1:0] LAST_IDX = TAP_IDX_W'(EST_DEPTH - 1);

    // PAM4 symbol levels.
    localparam int SYM_W = 3;
    localparam logic signed [SYM_W-1:0] SYM_P3 = 3'sd3;
    localparam logic signed [SYM_W-1:0] SYM_P1 = 3'sd1;
    localparam logic signed [SYM_W-1:0] SYM_M1 = -3'sd1;
    localparam logic signed [SYM_W-1:0] SYM_M3 = -3'sd3;

    // Instruction port.
    localparam int INST_W = 3;
    localparam logic [INST_W-1:0] INST_LOAD = 3'b100;

endpackage : chan_est_pkg

//--- hw/tap_index_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tap_index_counter
    import chan_est_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 clr,
    input  wire logic                 step,
    output logic [TAP_IDX_W-1:0]      tap_idx,
    output logic                      last_tap
);

    // Terminal flag, the one place the last tap is decoded.
    assign last_tap = (tap_idx == LAST_IDX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_idx <= '0;
        end else if (clr) begin
            tap_idx <= '0;
        end else if (step) begin
            // Wrap back to tap 0 after the last tap.
            if (last_tap) begin
                tap_idx <= '0;
            end else begin
                tap_idx <= tap_idx + 1'b1;
            end
        end
    end

endmodule : tap_index_counter

`default_nettype wire

//--- hw/chan_est_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module chan_est_ctrl
    import chan_est_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              exec_inst,
    input  wire logic [INST_W-1:0] inst,
    input  wire logic              last_tap,
    output logic                   calc_en,
    output logic                   store_en,
    output logic                   sample_en,
    output logic                   load_en,
    output logic                   count_clr,
    output logic                   count_step,
    output logic                   sweep_done,
    output logic                   halted
);

    typedef enum logic [2:0] {
        RESET,
        CALC,
        STORE,
        EXEC,
        HALT
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RESET;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state.
    always_comb begin
        state_nxt = state;
        case (state)
            RESET: state_nxt = exec_inst ? EXEC : CALC;
            CALC:  state_nxt = exec_inst ? EXEC : STORE;
            STORE: state_nxt = CALC;
            EXEC:  state_nxt = HALT;
            HALT:  state_nxt = exec_inst ? HALT : CALC;
            default: state_nxt = RESET;
        endcase
    end

    // Strobe decode.
    always_comb begin
        calc_en    = 1'b0;
        store_en   = 1'b0;
        sample_en  = 1'b0;
        load_en    = 1'b0;
        count_clr  = 1'b0;
        count_step = 1'b0;
        sweep_done = 1'b0;
        halted     = 1'b0;
        case (state)
            CALC: begin
                calc_en = 1'b1;
            end
            STORE: begin
                store_en   = 1'b1;
                count_step = 1'b1;
                // Snapshot taken on the store of the last tap.
                sample_en  = last_tap;
                sweep_done = last_tap;
            end
            EXEC: begin
                count_clr = 1'b1;
                // Only the load opcode has an effect.
                load_en   = (inst == INST_LOAD);
            end
            HALT: begin
                halted = 1'b1;
            end
            default: begin
                calc_en = 1'b0;
            end
        endcase
    end

endmodule : chan_est_ctrl

`default_nettype wire

//--- hw/lms_tap_update.sv
`timescale 1ns/1ps
`default_nettype none

module lms_tap_update
    import chan_est_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic signed [ERR_W-1:0]     error [ERR_LANES],
    input  wire logic signed [SYM_W-1:0]     current_bit,
    input  wire logic [GAIN_W-1:0]           gain,
    input  wire logic signed [EST_W-1:0]     load_val,
    input  wire logic [TAP_IDX_W-1:0]        load_addr,
    input  wire logic [TAP_IDX_W-1:0]        tap_idx,
    input  wire logic                        calc_en,
    input  wire logic                        store_en,
    input  wire logic                        sample_en,
    input  wire logic                        load_en,
    output logic signed [EST_W-1:0]          est_chan [EST_DEPTH]
);

    // Slicer outputs held for one sweep.
    logic signed [ERR_W-1:0] snap_err [EST_DEPTH];
    logic signed [SYM_W-1:0] snap_sym;

    // Step path.
    logic signed [ACC_W-1:0] err_ext;
    logic signed [ACC_W-1:0] err_shift;
    logic signed [ACC_W-1:0] err_x3;
    logic signed [ACC_W-1:0] step;

    // Candidate tap and the accumulator memory.
    logic signed [ACC_W-1:0] tap_decimal;
    logic signed [ACC_W-1:0] acc [EST_DEPTH];
    logic signed [ACC_W-1:0] load_acc;
    logic signed [ACC_W-1:0] acc_rel [EST_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < EST_DEPTH; i++) begin
                snap_err[i] <= '0;
            end
            snap_sym <= '0;
        end else if (sample_en) begin
            for (int i = 0; i < EST_DEPTH; i++) begin
                snap_err[i] <= error[i];
            end
            snap_sym <= current_bit;
        end
    end

    // Sign extend the selected lane before the gain shift.
    assign err_ext   = ACC_W'(snap_err[tap_idx]);
    assign err_shift = err_ext <<< gain;
    assign err_x3    = err_shift + (err_shift <<< 1);

    // Inner levels weigh three times the outer ones.
    always_comb begin
        case (snap_sym)
            SYM_P3:  step = -err_shift;
            SYM_P1:  step = -err_x3;
            SYM_M1:  step = err_x3;
            SYM_M3:  step = err_shift;
            default: step = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (calc_en) begin
            tap_decimal <= acc[tap_idx] + step;
        end
    end

    // Load value lands on the integer part of the accumulator.
    assign load_acc = {load_val, {ADAPT_W{1'b0}}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < EST_DEPTH; i++) begin
                acc[i] <= '0;
            end
        end else if (load_en) begin
            if (load_addr <= LAST_IDX) begin
                acc[load_addr] <= load_acc;
            end
        end else if (store_en) begin
            acc[tap_idx] <= tap_decimal;
        end
    end

    // Normalize against the last tap and drop the fraction bits.
    always_comb begin
        for (int i = 0; i < EST_DEPTH; i++) begin
            acc_rel[i]  = acc[i] - acc[EST_DEPTH-1];
            est_chan[i] = EST_W'(acc_rel[i] >>> ADAPT_W);
        end
    end

endmodule : lms_tap_update

`default_nettype wire

//--- hw/chan_est_top.sv
`timescale 1ns/1ps
`default_nettype none

module chan_est_top
    import chan_est_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic signed [ERR_W-1:0]     error [ERR_LANES],
    input  wire logic signed [SYM_W-1:0]     current_bit,
    input  wire logic [GAIN_W-1:0]           gain,
    input  wire logic [INST_W-1:0]           inst,
    input  wire logic                        exec_inst,
    input  wire logic signed [EST_W-1:0]     load_val,
    input  wire logic [TAP_IDX_W-1:0]        load_addr,
    output logic signed [EST_W-1:0]          est_chan [EST_DEPTH],
    output logic                             sweep_done,
    output logic                             halted
);

    logic [TAP_IDX_W-1:0] tap_idx;
    logic                 last_tap;
    logic                 calc_en;
    logic                 store_en;
    logic                 sample_en;
    logic                 load_en;
    logic                 count_clr;
    logic                 count_step;

    chan_est_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_inst  (exec_inst),
        .inst       (inst),
        .last_tap   (last_tap),
        .calc_en    (calc_en),
        .store_en   (store_en),
        .sample_en  (sample_en),
        .load_en    (load_en),
        .count_clr  (count_clr),
        .count_step (count_step),
        .sweep_done (sweep_done),
        .halted     (halted)
    );

    tap_index_counter u_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .clr      (count_clr),
        .step     (count_step),
        .tap_idx  (tap_idx),
        .last_tap (last_tap)
    );

    lms_tap_update u_lms (
        .clk         (clk),
        .rst_n       (rst_n),
        .error       (error),
        .current_bit (current_bit),
        .gain        (gain),
        .load_val    (load_val),
        .load_addr   (load_addr),
        .tap_idx     (tap_idx),
        .calc_en     (calc_en),
        .store_en    (store_en),
        .sample_en   (sample_en),
        .load_en     (load_en),
        .est_chan    (est_chan)
    );

endmodule : chan_est_top

`default_nettype wire

//--- verif/chan_est_sva.sv
`timescale 1ns/1ps

module chan_est_sva
    import chan_est_pkg::*;
(
    input wire logic                    clk,
    input wire logic                    rst_n,
    input wire logic                    exec_inst,
    input wire logic                    sweep_done,
    input wire logic                    halted,
    input wire logic signed [EST_W-1:0] est_chan [EST_DEPTH]
);

    logic [EST_DEPTH*EST_W-1:0] est_flat;
    logic                       after_rst;
    logic                       armed;
    int unsigned                since_sweep;
    int                         period_fails = 0;
    int                         hold_fails = 0;
    int                         reset_fails = 0;
    int                         fail_count;

    always_comb begin
        for (int i = 0; i < EST_DEPTH; i++) begin
            est_flat[i*EST_W +: EST_W] = est_chan[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            after_rst <= 1'b1;
        end else begin
            after_rst <= 1'b0;
        end
    end

    // Cycles since the last sweep_done, valid while no instruction arrives.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed       <= 1'b0;
            since_sweep <= 0;
        end else if (sweep_done) begin
            armed       <= 1'b1;
            since_sweep <= 1;
        end else if (exec_inst) begin
            armed <= 1'b0;
        end else if (armed) begin
            since_sweep <= since_sweep + 1;
        end
    end

    assign fail_count = period_fails + hold_fails + reset_fails;

    a_sweep_period: assert property (@(posedge clk) disable iff (!rst_n)
        (armed && since_sweep == 2 * EST_DEPTH) |-> sweep_done)
        else begin
            $error("sweep_done did not recur one sweep after the previous pulse");
            period_fails++;
        end

    a_sweep_gap: assert property (@(posedge clk) disable iff (!rst_n)
        (armed && since_sweep > 0 && since_sweep < 2 * EST_DEPTH) |-> !sweep_done)
        else begin
            $error("sweep_done pulsed early or stayed high");
            period_fails++;
        end

    a_halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> (!halted || $stable(est_flat)))
        else begin
            $error("est_chan changed while halted");
            hold_fails++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        (after_rst && rst_n) |-> (!sweep_done && !halted))
        else begin
            $error("sweep_done or halted high in the first cycle after reset");
            reset_fails++;
        end

endmodule : chan_est_sva

bind chan_est_top chan_est_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .exec_inst  (exec_inst),
    .sweep_done (sweep_done),
    .halted     (halted),
    .est_chan   (est_chan)
);

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 20 ns period.
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Reset held low over the first two rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule : tb_clock

//--- verif/chan_est_tb.sv
`timescale 1ns/1ps

module chan_est_tb
    import chan_est_pkg::*;
();

    localparam int SWEEP_CYCLES = 2 * EST_DEPTH;
    localparam int TEST_SWEEPS  = 25;
    localparam int EXEC_COUNT   = 32;
    localparam int MAX_CYCLES   = TEST_SWEEPS * SWEEP_CYCLES + EXEC_COUNT * 8 + 200;

    // Controller states of the reference model.
    localparam int M_RESET = 0;
    localparam int M_CALC  = 1;
    localparam int M_STORE = 2;
    localparam int M_EXEC  = 3;
    localparam int M_HALT  = 4;

    logic                    clk;
    logic                    rst_n;
    logic signed [ERR_W-1:0] error [ERR_LANES];
    logic signed [SYM_W-1:0] current_bit;
    logic [GAIN_W-1:0]       gain;
    logic [INST_W-1:0]       inst;
    logic                    exec_inst;
    logic signed [EST_W-1:0] load_val;
    logic [TAP_IDX_W-1:0]    load_addr;
    logic signed [EST_W-1:0] est_chan [EST_DEPTH];
    logic                    sweep_done;
    logic                    halted;

    // Reference model state.
    longint model_acc [EST_DEPTH];
    int     snap_err [EST_DEPTH];
    int     snap_sym = 0;
    int     m_state = M_RESET;
    int     m_tap = 0;
    logic   sweep_exp;
    logic   halted_exp;
    int     errors = 0;
    int     cycles = 0;
    int     sym_list [5] = '{3, 1, -1, -3, -4};

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    chan_est_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .error       (error),
        .current_bit (current_bit),
        .gain        (gain),
        .inst        (inst),
        .exec_inst   (exec_inst),
        .load_val    (load_val),
        .load_addr   (load_addr),
        .est_chan    (est_chan),
        .sweep_done  (sweep_done),
        .halted      (halted)
    );

    // Symbol weight of the sign-weighted LMS step.
    function automatic longint step_weight(input int sym);
        case (sym)
            3:       return -1;
            1:       return -3;
            -1:      return 3;
            -3:      return 1;
            default: return 0;
        endcase
    endfunction

    task automatic check_outputs();
        longint                  diff;
        logic signed [EST_W-1:0] exp_w;
        for (int i = 0; i < EST_DEPTH; i++) begin
            diff  = (model_acc[i] - model_acc[EST_DEPTH-1]) >>> ADAPT_W;
            exp_w = EST_W'(diff);
            assert (est_chan[i] == exp_w) else begin
                $display("Mismatch est_chan[%0d]: got %h expected %h", i, est_chan[i], exp_w);
                errors++;
            end
        end
    endtask

    // Model sampled mid-cycle where the outputs are settled.
    always @(negedge clk) begin
        if (!rst_n) begin
            m_state = M_RESET;
            m_tap   = 0;
        end
        sweep_exp  = (m_state == M_STORE) && (m_tap == EST_DEPTH - 1);
        halted_exp = (m_state == M_HALT);
        assert (sweep_done == sweep_exp) else begin
            $display("Mismatch sweep_done: got %h expected %h", sweep_done, sweep_exp);
            errors++;
        end
        assert (halted == halted_exp) else begin
            $display("Mismatch halted: got %h expected %h", halted, halted_exp);
            errors++;
        end
        if (m_state == M_RESET || m_state == M_HALT || (m_state == M_CALC && m_tap == 0)) begin
            check_outputs();
        end
        if (sweep_exp) begin
            for (int i = 0; i < EST_DEPTH; i++) begin
                model_acc[i] += longint'(snap_err[i]) * (longint'(1) << gain)
                                * step_weight(snap_sym);
                snap_err[i] = int'(error[i]);
            end
            snap_sym = int'(current_bit);
        end
        if (m_state == M_EXEC && inst == INST_LOAD && load_addr < EST_DEPTH) begin
            model_acc[load_addr] = longint'(load_val) * (longint'(1) << ADAPT_W);
        end
        // Next state from the inputs seen by the coming rising edge.
        if (rst_n) begin
            case (m_state)
                M_RESET: m_state = exec_inst ? M_EXEC : M_CALC;
                M_CALC:  m_state = exec_inst ? M_EXEC : M_STORE;
                M_STORE: begin
                    m_state = M_CALC;
                    m_tap   = (m_tap == EST_DEPTH - 1) ? 0 : m_tap + 1;
                end
                M_EXEC: begin
                    m_state = M_HALT;
                    m_tap   = 0;
                end
                default: m_state = exec_inst ? M_HALT : M_CALC;
            endcase
        end
    end

    task automatic run_exec(input logic [INST_W-1:0] op, input int addr, input int val,
                            input int hold);
        int waited;
        exec_inst = 1'b1;
        inst      = op;
        load_addr = TAP_IDX_W'(addr);
        load_val  = EST_W'(val);
        waited    = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!halted && waited < 8);
        if (!halted) begin
            $display("Controller did not enter HALT after exec_inst was raised");
            errors++;
        end
        repeat (hold) @(negedge clk);
        @(posedge clk);
        #1;
        exec_inst = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_sweeps(input int n);
        int waited;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!sweep_done && waited < SWEEP_CYCLES + 10);
            if (!sweep_done) begin
                $display("No sweep_done within %0d cycles", SWEEP_CYCLES + 10);
                errors++;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic drive_slicer(input int sym, input logic zero);
        for (int i = 0; i < ERR_LANES; i++) begin
            error[i] = zero ? '0 : ERR_W'(int'($urandom_range(30)) - 15);
        end
        current_bit = SYM_W'(sym);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int op;
        void'($urandom(32'hbba1_55fa));
        for (int i = 0; i < EST_DEPTH; i++) begin
            model_acc[i] = 0;
            snap_err[i]  = 0;
        end
        exec_inst = 1'b0;
        inst      = '0;
        load_val  = '0;
        load_addr = '0;
        gain      = '0;
        drive_slicer(0, 1'b1);
        @(posedge rst_n);
        @(posedge clk);
        #1;
        // Load every tap with a zero snapshot and reload tap 29.
        for (int i = 0; i < EST_DEPTH; i++) begin
            run_exec(INST_LOAD, i, int'($urandom_range(400)) - 200, 0);
        end
        run_exec(INST_LOAD, EST_DEPTH - 1, int'($urandom_range(400)) - 200, 0);
        // Halt on a non-load opcode.
        op = int'($urandom_range(6));
        if (op >= 4) begin
            op++;
        end
        run_exec(INST_W'(op), 0, 0, 4 + int'($urandom_range(11)));
        wait_sweeps(2);
        // Adaptation for each symbol ending with an illegal one.
        gain = GAIN_W'(13);
        for (int s = 0; s < 5; s++) begin
            drive_slicer(sym_list[s], 1'b0);
            wait_sweeps(3);
        end
        gain = GAIN_W'(11);
        drive_slicer(1, 1'b0);
        wait_sweeps(3);
        gain = GAIN_W'(15);
        drive_slicer(-3, 1'b0);
        wait_sweeps(3);
        drive_slicer(0, 1'b1);
        wait_sweeps(2);
        run_exec(INST_LOAD, int'($urandom_range(EST_DEPTH - 1)),
                 int'($urandom_range(400)) - 200, 2);
        repeat (2) @(negedge clk);
        $display("Errors: %0d testbench, %0d assertion", errors, UUT.u_sva.fail_count);
        if (errors == 0 && UUT.u_sva.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : chan_est_tb

//--- filelist.f
hw/chan_est_pkg.sv
hw/tap_index_counter.sv
hw/chan_est_ctrl.sv
hw/lms_tap_update.sv
hw/chan_est_top.sv
verif/chan_est_sva.sv
verif/tb_clock.sv
verif/chan_est_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the channel estimator testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module chan_est_tb \
    -o chan_est_sim

./obj_dir/chan_est_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a status line, see sim.log"
    exit 1
fi
